//--- include/kcpu_defs.svh
// size macros for the microcode control unit
// address, category and word widths of the microcode store

`ifndef KCPU_DEFS_SVH
`define KCPU_DEFS_SVH

// microcode store depth as address bits
`define KCPU_UCODE_AW 10    // 1024 rows

// routine categories coming out of the opcode decoder
`define KCPU_OPCAT_AW 5     // 32 categories

// rows reserved for each routine
`define KCPU_ROW_BITS 4     // 16 rows per routine

// one microcode row
`define KCPU_UCODE_DW 24

`endif

//--- design/kcpu_pkg.sv
// opcodes, routine categories, decoder output, microword views and control bundle
// shared by decoder, sequencer and control stage

`include "kcpu_defs.svh"

package kcpu_pkg;

    // opcodes handled by the control unit
    localparam logic [7:0] op_adda_imm = 8'h8b;
    localparam logic [7:0] op_addb_imm = 8'hcb;
    localparam logic [7:0] op_adda_idx = 8'hab;
    localparam logic [7:0] op_addb_idx = 8'heb;
    localparam logic [7:0] op_lsrw     = 8'h54;  // word shift, multi-cycle
    localparam logic [7:0] op_rorw     = 8'h56;
    localparam logic [7:0] op_div      = 8'h8d;  // long divide
    localparam logic [7:0] op_bra      = 8'h20;
    localparam logic [7:0] op_beq      = 8'h27;
    localparam logic [7:0] op_pshs     = 8'h34;
    localparam logic [7:0] op_puls     = 8'h35;
    localparam logic [7:0] op_nop      = 8'h12;

    // routine categories, each owns 16 rows starting at cat*16
    typedef enum logic [`KCPU_OPCAT_AW-1:0] {
        cat_reset      = 5'd0,
        cat_alu_single = 5'd1,
        cat_alu_multi  = 5'd2,
        cat_branch     = 5'd3,
        cat_stack      = 5'd4,
        cat_nop        = 5'd5,
        cat_buserror   = 5'd31   // stop routine
    } opcat_e;

    typedef struct packed {
        opcat_e opcat;
        logic   idx_src;         // source operand needs indexed decode
    } dec_t;

    // jump conditions tested against the branch input
    typedef enum logic [1:0] {
        jc_always  = 2'd0,
        jc_branch  = 2'd1,
        jc_nbranch = 2'd2        // code 3 never jumps
    } jcond_e;

    // control row, bit 23 clear
    typedef struct packed {
        logic       kind;        // 0
        logic       ni;          // bit 22, next instruction
        logic       pul_go;      // bit 21
        logic       psh_go;      // bit 20
        logic       alu_go;      // bit 19
        logic [3:0] alu_sel;     // bits 18:15
        logic       wait_alu;    // bit 14, hold while alu_busy
        logic       buserror;    // bit 13
        logic [`KCPU_UCODE_DW-12:0] spare;
    } uctl_t;

    // jump row, bit 23 set
    typedef struct packed {
        logic                      kind;    // 1
        jcond_e                    cond;    // bits 22:21
        logic [`KCPU_UCODE_AW-1:0] target;  // bits 20:11
        logic [`KCPU_UCODE_DW-`KCPU_UCODE_AW-4:0] spare;
    } ujmp_t;

    // one row read either way depending on bit 23
    typedef union packed {
        uctl_t ctl;
        ujmp_t jmp;
    } uword_t;

    typedef struct packed {
        logic       ni;
        logic       pul_go;
        logic       psh_go;
        logic       alu_go;
        logic [3:0] alu_sel;
        logic       idx_src;     // only valid with ni
        logic       buserror;
    } ctrl_t;

endpackage

//--- design/kcpu_opdec.sv
// opcode decoder
// maps the opcode byte to a routine category and the index-mode flag

module kcpu_opdec (
    input  logic [7:0]      op,    // opcode byte from fetch
    output kcpu_pkg::dec_t  dec
);

    kcpu_pkg::opcat_e opcat;
    logic             idx_src;

    // category table
    // several opcodes share one microcode routine
    always_comb begin
        case (op)
            kcpu_pkg::op_adda_imm,
            kcpu_pkg::op_addb_imm,
            kcpu_pkg::op_adda_idx,
            kcpu_pkg::op_addb_idx: begin
                opcat = kcpu_pkg::cat_alu_single;  // result in one cycle
            end
            kcpu_pkg::op_lsrw,
            kcpu_pkg::op_rorw,
            kcpu_pkg::op_div: begin
                opcat = kcpu_pkg::cat_alu_multi;   // alu_busy paced
            end
            kcpu_pkg::op_bra,
            kcpu_pkg::op_beq: begin
                opcat = kcpu_pkg::cat_branch;
            end
            kcpu_pkg::op_pshs,
            kcpu_pkg::op_puls: begin
                opcat = kcpu_pkg::cat_stack;
            end
            kcpu_pkg::op_nop: begin
                opcat = kcpu_pkg::cat_nop;
            end
            default: begin
                opcat = kcpu_pkg::cat_buserror;    // unknown code stops the core
            end
        endcase
    end

    // indexed adds fetch their operand through the index unit first
    always_comb begin
        case (op)
            kcpu_pkg::op_adda_idx,
            kcpu_pkg::op_addb_idx: begin
                idx_src = 1'b1;
            end
            default: begin
                idx_src = 1'b0;
            end
        endcase
    end

    always_comb begin
        dec.opcat   = opcat;
        dec.idx_src = idx_src;
    end

endmodule

//--- design/kcpu_useq.sv
// microcode sequencer
// microcode store, address register and next-address selection

`include "kcpu_defs.svh"

module kcpu_useq (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  kcpu_pkg::dec_t    dec,
    input  logic              branch,    // condition from the datapath
    input  logic              alu_busy,
    input  logic              halted,    // set by the control stage on bus error
    output kcpu_pkg::uword_t  uword      // row at the current address
);

    localparam int aw = `KCPU_UCODE_AW;

    logic [`KCPU_UCODE_DW-1:0] mem [0:(1 << `KCPU_UCODE_AW)-1];
    logic [aw-1:0]             addr;     // row being read
    logic [aw-1:0]             addr_nx;
    logic                      take;     // jump condition holds
    logic                      hold;     // wait row with busy alu

    // first row of a category routine
    function automatic logic [aw-1:0] cat_row(input kcpu_pkg::opcat_e cat);
        return aw'(cat) << `KCPU_ROW_BITS;
    endfunction

    // store contents come from the assembled microcode image
    initial begin
        $readmemh("ucode.hex", mem);
    end

    assign uword = mem[addr];  // asynchronous read

    always_comb begin
        case (uword.jmp.cond)
            kcpu_pkg::jc_always:  take = 1'b1;
            kcpu_pkg::jc_branch:  take = branch;
            kcpu_pkg::jc_nbranch: take = ~branch;
            default:              take = 1'b0;
        endcase
    end

    assign hold = ~uword.ctl.kind & uword.ctl.wait_alu & alu_busy;

    // next-address rules
    always_comb begin
        addr_nx = addr + aw'(1);               // plain step through the routine
        if (uword.jmp.kind) begin
            if (take) begin
                addr_nx = uword.jmp.target;
            end
        end else if (hold) begin
            addr_nx = addr;                     // stay until the alu is done
        end else if (uword.ctl.ni) begin
            addr_nx = cat_row(dec.opcat);       // op sampled here
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            addr <= cat_row(kcpu_pkg::cat_reset);  // row 0
        end else if (cen && !halted) begin
            addr <= addr_nx;
        end
    end

endmodule

//--- design/kcpu_uctl.sv
// control output stage
// turns each executed microcode row into one-cycle control pulses, tracks halt

module kcpu_uctl (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  kcpu_pkg::uword_t  uword,     // current row from the sequencer
    input  kcpu_pkg::dec_t    dec,
    input  logic              alu_busy,
    output kcpu_pkg::ctrl_t   ctrl,
    output logic              halted     // sticky until reset
);

    logic is_ctl;   // control row, not a jump
    logic held;     // wait row still blocked
    logic exec;     // row runs this cycle

    assign is_ctl = ~uword.ctl.kind;
    assign held   = uword.ctl.wait_alu & alu_busy;
    assign exec   = cen & ~halted & is_ctl & ~held;

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl   <= '0;
            halted <= 1'b0;
        end else begin
            ctrl <= '0;  // every pulse lasts a single clk
            if (exec) begin
                ctrl.ni       <= uword.ctl.ni;
                ctrl.pul_go   <= uword.ctl.pul_go;
                ctrl.psh_go   <= uword.ctl.psh_go;
                ctrl.alu_go   <= uword.ctl.alu_go;
                ctrl.alu_sel  <= uword.ctl.alu_sel;
                ctrl.buserror <= uword.ctl.buserror;
                // operand mode of the op picked up by this ni row
                ctrl.idx_src  <= uword.ctl.ni & dec.idx_src;
                if (uword.ctl.buserror) begin
                    halted <= 1'b1;                 // sequencer stops here
                end
            end
        end
    end

endmodule

//--- design/kcpu_ctrl.sv
// top of the microcode control unit
// opcode decoder, sequencer and control stage

module kcpu_ctrl (
    input  logic             clk,
    input  logic             rst,
    input  logic             cen,
    input  logic [7:0]       op,        // opcode byte
    input  logic             branch,
    input  logic             alu_busy,
    output kcpu_pkg::ctrl_t  ctrl
);

    kcpu_pkg::dec_t   dec;      // decoded opcode
    kcpu_pkg::uword_t uword;    // current microcode row
    logic             halted;   // bus error stop

    kcpu_opdec u_opdec (
        .op  (op),
        .dec (dec)
    );

    kcpu_useq u_useq (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .dec      (dec),
        .branch   (branch),
        .alu_busy (alu_busy),
        .halted   (halted),
        .uword    (uword)
    );

    // pulses follow the addressed row by one cycle
    kcpu_uctl u_uctl (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .uword    (uword),
        .dec      (dec),
        .alu_busy (alu_busy),
        .ctrl     (ctrl),
        .halted   (halted)
    );

endmodule

//--- sim/tb_kcpu_ctrl.sv
// testbench for the microcode control unit
// clock, reset, microcode reference model, compare tasks and directed tests

`include "kcpu_defs.svh"

module tb_kcpu_ctrl;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int aw          = `KCPU_UCODE_AW;
    localparam int tests       = 6;
    localparam int test_cycles = 40;                      // longest test is the bus error one
    localparam int cycle_limit = tests * test_cycles + 160;  // 400 cycles with margin

    localparam logic [7:0]      op_unused = 8'hff;       // not in the opcode table
    localparam kcpu_pkg::ctrl_t no_pulse  = '0;

    logic            clk      = 1'b0;
    logic            rst      = 1'b1;
    logic            cen      = 1'b0;
    logic [7:0]      op       = kcpu_pkg::op_nop;
    logic            branch   = 1'b0;
    logic            alu_busy = 1'b0;
    kcpu_pkg::ctrl_t ctrl;

    logic [`KCPU_UCODE_DW-1:0] rom [0:(1 << `KCPU_UCODE_AW)-1];  // model copy of the store
    logic [aw-1:0]             m_addr;                 // model address register
    logic                      m_halted;
    kcpu_pkg::ctrl_t           exp_ctrl;               // ctrl expected after the last edge
    logic                      model_on = 1'b0;        // set by the first reset edge
    int                        cycles   = 0;
    integer                    seed     = 32'h7091;

    kcpu_ctrl u_kcpu_ctrl (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .op       (op),
        .branch   (branch),
        .alu_busy (alu_busy),
        .ctrl     (ctrl)
    );

    always #10 clk = ~clk;  // 20 ns period

    initial begin
        $readmemh("ucode.hex", rom);
    end

    // routine category of an opcode, straight from the opcode groups
    function automatic kcpu_pkg::opcat_e opcode_category(input logic [7:0] code);
        kcpu_pkg::opcat_e c;
        c = kcpu_pkg::cat_buserror;  // every code outside the table
        if (code == kcpu_pkg::op_adda_imm || code == kcpu_pkg::op_addb_imm ||
            code == kcpu_pkg::op_adda_idx || code == kcpu_pkg::op_addb_idx) begin
            c = kcpu_pkg::cat_alu_single;
        end else if (code == kcpu_pkg::op_lsrw || code == kcpu_pkg::op_rorw ||
                     code == kcpu_pkg::op_div) begin
            c = kcpu_pkg::cat_alu_multi;
        end else if (code == kcpu_pkg::op_bra || code == kcpu_pkg::op_beq) begin
            c = kcpu_pkg::cat_branch;
        end else if (code == kcpu_pkg::op_pshs || code == kcpu_pkg::op_puls) begin
            c = kcpu_pkg::cat_stack;
        end else if (code == kcpu_pkg::op_nop) begin
            c = kcpu_pkg::cat_nop;
        end
        return c;
    endfunction

    function automatic logic opcode_indexed(input logic [7:0] code);
        return (code == kcpu_pkg::op_adda_idx) || (code == kcpu_pkg::op_addb_idx);
    endfunction

    function automatic kcpu_pkg::ctrl_t make_ctrl(input logic ni, input logic alu_go,
            input logic [3:0] alu_sel, input logic psh_go, input logic pul_go,
            input logic idx_src, input logic buserror);
        kcpu_pkg::ctrl_t c;
        c          = no_pulse;
        c.ni       = ni;
        c.alu_go   = alu_go;
        c.alu_sel  = alu_sel;
        c.psh_go   = psh_go;
        c.pul_go   = pul_go;
        c.idx_src  = idx_src;
        c.buserror = buserror;
        return c;
    endfunction

    // reference sequencer, runs on the same edge with the same pre-edge inputs
    always @(posedge clk) begin : ref_model
        kcpu_pkg::uword_t w;
        kcpu_pkg::ctrl_t  e;
        logic [aw-1:0]    nxt;
        logic             jump;
        if (rst) begin
            m_addr   <= '0;
            m_halted <= 1'b0;
            exp_ctrl <= no_pulse;
            model_on <= 1'b1;
        end else begin
            w    = kcpu_pkg::uword_t'(rom[m_addr]);
            e    = no_pulse;                    // jump rows and frozen cycles pulse nothing
            nxt  = m_addr + aw'(1);
            jump = 1'b0;
            if (cen && !m_halted) begin
                if (w.jmp.kind) begin
                    case (w.jmp.cond)
                        kcpu_pkg::jc_always:  jump = 1'b1;
                        kcpu_pkg::jc_branch:  jump = branch;
                        kcpu_pkg::jc_nbranch: jump = !branch;
                        default:              jump = 1'b0;
                    endcase
                    if (jump) begin
                        nxt = w.jmp.target;
                    end
                end else if (w.ctl.wait_alu && alu_busy) begin
                    nxt = m_addr;                   // held wait row
                end else begin
                    e.ni       = w.ctl.ni;
                    e.pul_go   = w.ctl.pul_go;
                    e.psh_go   = w.ctl.psh_go;
                    e.alu_go   = w.ctl.alu_go;
                    e.alu_sel  = w.ctl.alu_sel;
                    e.buserror = w.ctl.buserror;
                    e.idx_src  = w.ctl.ni & opcode_indexed(op);
                    if (w.ctl.ni) begin
                        nxt = aw'(opcode_category(op)) * aw'(1 << `KCPU_ROW_BITS);
                    end
                    if (w.ctl.buserror) begin
                        m_halted <= 1'b1;
                    end
                end
                m_addr <= nxt;
            end
            exp_ctrl <= e;
        end
    end

    task automatic check_ctrl(input kcpu_pkg::ctrl_t got, input kcpu_pkg::ctrl_t want,
                              input string what);
        if (got !== want) begin
            $display("FAILED ctrl (%s): got 0x%h expected 0x%h", what, got, want);
            $display("Checks failed");
            $fatal(1, "ctrl mismatch at cycle %0d", cycles);
        end
    endtask

    // a run of cycles with every control pulse low
    task automatic check_halt(input int n);
        repeat (n) begin
            @(negedge clk);
            check_ctrl(ctrl, no_pulse, "halted core");
        end
    endtask

    // every cycle against the reference model, sampled mid-cycle
    always @(negedge clk) begin
        if (model_on) begin
            check_ctrl(ctrl, exp_ctrl, "reference model");
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the DUT never reached the expected pulse", cycles);
            $display("Checks failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic apply_reset();
        @(posedge clk);
        rst      <= 1'b1;
        cen      <= 1'b1;
        op       <= kcpu_pkg::op_nop;  // idle loop after release
        branch   <= 1'b0;
        alu_busy <= 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
    endtask

    // row 0 runs on the release edge
    task automatic expect_first_ni();
        @(negedge clk);
        check_ctrl(ctrl, no_pulse, "last reset cycle");
        @(negedge clk);
        check_ctrl(ctrl, make_ctrl(1'b1, 1'b0, 4'd0, 1'b0, 1'b0, 1'b0, 1'b0), "first ni");
    endtask

    task automatic wait_ni();
        @(negedge clk);
        while (!ctrl.ni) begin
            @(negedge clk);
        end
    endtask

    // nop loop picks up code on its next ni row, returns on the routine's first edge
    task automatic issue_op(input logic [7:0] code, input logic idx);
        @(posedge clk);
        op <= code;
        @(posedge clk);   // ni row samples code here
        wait_ni();
        check_ctrl(ctrl, make_ctrl(1'b1, 1'b0, 4'd0, 1'b0, 1'b0, idx, 1'b0), "ni picking up op");
        @(posedge clk);
        op <= kcpu_pkg::op_nop;
    endtask

    task automatic drive_random_ops(input int n);
        repeat (n) begin
            @(posedge clk);
            op <= 8'($random(seed));
        end
    endtask

    task automatic reset_and_add();
        apply_reset();
        expect_first_ni();
        issue_op(kcpu_pkg::op_adda_idx, 1'b1);
        @(negedge clk);
        check_ctrl(ctrl, make_ctrl(1'b0, 1'b1, 4'd1, 1'b0, 1'b0, 1'b0, 1'b0), "adda_idx alu_go");
        @(negedge clk);
        check_ctrl(ctrl, make_ctrl(1'b1, 1'b0, 4'd0, 1'b0, 1'b0, 1'b0, 1'b0), "adda_idx end");
        issue_op(kcpu_pkg::op_addb_imm, 1'b0);
        @(negedge clk);
        check_ctrl(ctrl, make_ctrl(1'b0, 1'b1, 4'd1, 1'b0, 1'b0, 1'b0, 1'b0), "addb_imm alu_go");
        @(negedge clk);
        check_ctrl(ctrl, make_ctrl(1'b1, 1'b0, 4'd0, 1'b0, 1'b0, 1'b0, 1'b0), "addb_imm end");
    endtask

    task automatic divide_with_busy();
        int busy_len;
        busy_len = 1 + ($random(seed) & 7);  // 1 to 8 cycles
        issue_op(kcpu_pkg::op_div, 1'b0);
        alu_busy <= 1'b1;                     // seen first by the wait row
        @(negedge clk);
        check_ctrl(ctrl, make_ctrl(1'b0, 1'b1, 4'd2, 1'b0, 1'b0, 1'b0, 1'b0), "div alu_go");
        for (int i = 0; i < busy_len; i++) begin
            @(posedge clk);
            if (i == busy_len - 1) begin
                alu_busy <= 1'b0;
            end
            @(negedge clk);
            check_ctrl(ctrl, no_pulse, "div wait while busy");
        end
        @(negedge clk);  // wait row released, it has no pulse of its own
        check_ctrl(ctrl, no_pulse, "div wait released");
        @(negedge clk);
        check_ctrl(ctrl, make_ctrl(1'b1, 1'b0, 4'd0, 1'b0, 1'b0, 1'b0, 1'b0), "div end");
    endtask

    task automatic branch_both_ways();
        issue_op(kcpu_pkg::op_beq, 1'b0);
        @(negedge clk);
        check_ctrl(ctrl, no_pulse, "beq jump row");
        @(negedge clk);
        check_ctrl(ctrl, make_ctrl(1'b1, 1'b0, 4'd0, 1'b0, 1'b0, 1'b0, 1'b0), "beq not taken");
        @(posedge clk);
        branch <= 1'b1;
        issue_op(kcpu_pkg::op_beq, 1'b0);
        @(negedge clk);
        check_ctrl(ctrl, no_pulse, "beq jump row taken");
        @(negedge clk);
        check_ctrl(ctrl, make_ctrl(1'b0, 1'b1, 4'd3, 1'b0, 1'b0, 1'b0, 1'b0), "beq target");
        @(negedge clk);
        check_ctrl(ctrl, make_ctrl(1'b1, 1'b0, 4'd0, 1'b0, 1'b0, 1'b0, 1'b0), "beq taken end");
        @(posedge clk);
        branch <= 1'b0;
    endtask

    task automatic push_pull();
        issue_op(kcpu_pkg::op_pshs, 1'b0);
        @(negedge clk);
        check_ctrl(ctrl, make_ctrl(1'b0, 1'b0, 4'd0, 1'b1, 1'b0, 1'b0, 1'b0), "pshs push");
        @(negedge clk);
        check_ctrl(ctrl, make_ctrl(1'b0, 1'b0, 4'd0, 1'b0, 1'b1, 1'b0, 1'b0), "pshs pull");
        @(negedge clk);
        check_ctrl(ctrl, make_ctrl(1'b1, 1'b0, 4'd0, 1'b0, 1'b0, 1'b0, 1'b0), "pshs end");
    endtask

    // freeze the core between the alu_go row and the wait row
    task automatic enable_gap();
        issue_op(kcpu_pkg::op_lsrw, 1'b0);
        cen <= 1'b0;
        @(negedge clk);
        check_ctrl(ctrl, make_ctrl(1'b0, 1'b1, 4'd2, 1'b0, 1'b0, 1'b0, 1'b0), "lsrw alu_go");
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            if (i == 3) begin
                cen <= 1'b1;
            end
            @(negedge clk);
            check_ctrl(ctrl, no_pulse, "cen low");
        end
        @(negedge clk);
        check_ctrl(ctrl, no_pulse, "lsrw wait row after cen");
        @(negedge clk);
        check_ctrl(ctrl, make_ctrl(1'b1, 1'b0, 4'd0, 1'b0, 1'b0, 1'b0, 1'b0), "lsrw end");
    endtask

    task automatic bus_error_halt();
        issue_op(op_unused, 1'b0);
        @(negedge clk);
        check_ctrl(ctrl, make_ctrl(1'b0, 1'b0, 4'd0, 1'b0, 1'b0, 1'b0, 1'b1), "bus error row");
        fork
            drive_random_ops(20);
            check_halt(20);
        join
        apply_reset();
        expect_first_ni();  // reset clears the halt
    endtask

    initial begin
        reset_and_add();
        divide_with_busy();
        branch_both_ways();
        push_pull();
        enable_gap();
        bus_error_halt();
        $display("All checks passed");
        $finish;
    end

endmodule

//--- ucode.hex
// microcode image for the control unit, one 24-bit microword in hex per line
// columns: @nnn sets the row address, each following line fills the next row
// ctl rows: bit 23 = 0, 22 ni, 21 pul_go, 20 psh_go, 19 alu_go,
//           18:15 alu_sel, 14 wait_alu, 13 buserror
// jmp rows: bit 23 = 1, 22:21 cond (0 always, 1 on branch, 2 on no branch),
//           20:11 target row
// routine of category n starts at row n*16

// reset routine, row 0 only fetches the first opcode
@000
400000   // ni

// single-cycle alu, category 1
@010
088000   // alu_go, alu_sel 1
400000   // ni

// multi-cycle alu, category 2
@020
090000   // alu_go, alu_sel 2
004000   // wait_alu, held while alu_busy
400000   // ni

// branch, category 3
@030
a1a000   // jump to row 034 when branch is high
400000   // not taken, ni

// taken path at offset 4
@034
098000   // alu_go, alu_sel 3 computes the target
400000   // ni

// stack, category 4
@040
100000   // psh_go
200000   // pul_go
400000   // ni

// nop, category 5
@050
400000   // ni

// bus error, category 31
@1f0
002000   // buserror, core halts after this row
8f8800   // parking jump onto itself, never executed once halted

//--- list.f
+incdir+include
design/kcpu_pkg.sv
design/kcpu_opdec.sv
design/kcpu_useq.sv
design/kcpu_uctl.sv
design/kcpu_ctrl.sv
sim/tb_kcpu_ctrl.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the control unit testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --top-module tb_kcpu_ctrl -f list.f -o tb_kcpu_ctrl \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_kcpu_ctrl > sim.log 2>&1
cat sim.log

grep -q "Checks failed" sim.log && { echo "simulation failed"; exit 1; } || echo "simulation passed"
